/* design/cpu_bus_pkg.sv */
package cpu_bus_pkg;

    typedef logic [31:0] word_t;

    localparam word_t reset_pc = 32'h0000_0000;

    // {inst, pc}
    localparam int fs_to_ds_bus_wd = 64;
    // alu_op, flags, dest, imm, rj, rkd, pc
    localparam int ds_to_es_bus_wd = 150;
    // ld, st, gr_we, dest, result, store data
    localparam int es_to_ms_bus_wd = 72;
    // {taken, target}
    localparam int br_bus_wd = 33;

endpackage

/* design/cpu_core.sv */
module cpu_core (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   mem_en,
    output logic                   mem_we,
    output cpu_bus_pkg::word_t     mem_addr,
    output cpu_bus_pkg::word_t     mem_wdata,
    input  cpu_bus_pkg::word_t     mem_rdata,
    output logic                   debug_wb_we,
    output cpu_isa_pkg::reg_addr_t debug_wb_addr,
    output cpu_bus_pkg::word_t     debug_wb_data
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic                       ds_allowin;
    logic                       es_allowin;
    logic                       ms_allowin;
    logic                       fs_to_ds_valid;
    logic [fs_to_ds_bus_wd-1:0] fs_to_ds_bus;
    logic                       ds_to_es_valid;
    logic [ds_to_es_bus_wd-1:0] ds_to_es_bus;
    logic                       es_to_ms_valid;
    logic [es_to_ms_bus_wd-1:0] es_to_ms_bus;
    logic [br_bus_wd-1:0]       br_bus;
    reg_addr_t                  es_dest;
    logic                       es_gr_we;
    reg_addr_t                  ms_dest;
    logic                       ms_gr_we;
    logic                       rf_we;
    reg_addr_t                  rf_waddr;
    word_t                      rf_wdata;
    logic                       inst_req;
    word_t                      inst_addr;
    logic                       inst_grant;
    word_t                      inst_rdata;
    logic                       data_req;
    logic                       data_we;
    word_t                      data_addr;
    word_t                      data_wdata;
    logic                       data_grant;
    word_t                      data_rdata;

    // stage ports share names with the nets above
    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    memwb_stage   u_memwb   (.*);
    mem_arbiter   u_arbiter (.*);

    // trace mirrors the register file write
    assign debug_wb_we   = rf_we;
    assign debug_wb_addr = rf_waddr;
    assign debug_wb_data = rf_wdata;

endmodule

/* design/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // one-hot alu operation bits
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // inst[31:26]
    localparam logic [5:0] op6_alu   = 6'h00;
    localparam logic [5:0] op6_lu12i = 6'h05;
    localparam logic [5:0] op6_mem   = 6'h0a;
    localparam logic [5:0] op6_jirl  = 6'h13;
    localparam logic [5:0] op6_b     = 6'h14;
    localparam logic [5:0] op6_bl    = 6'h15;
    localparam logic [5:0] op6_beq   = 6'h16;
    localparam logic [5:0] op6_bne   = 6'h17;

    // inst[25:22]
    localparam logic [3:0] op4_3r    = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_ld    = 4'h2;
    localparam logic [3:0] op4_st    = 4'h6;
    localparam logic [3:0] op4_addi  = 4'ha;

    // inst[21:20]
    localparam logic [1:0] op2_3r    = 2'h1;
    localparam logic [1:0] op2_shift = 2'h0;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

endpackage

/* design/decode_stage.sv */
module decode_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  es_allowin,
    output logic                                  ds_allowin,
    input  logic                                  fs_to_ds_valid,
    input  logic [cpu_bus_pkg::fs_to_ds_bus_wd-1:0] fs_to_ds_bus,
    output logic                                  ds_to_es_valid,
    output logic [cpu_bus_pkg::ds_to_es_bus_wd-1:0] ds_to_es_bus,
    output logic [cpu_bus_pkg::br_bus_wd-1:0]       br_bus,
    input  cpu_isa_pkg::reg_addr_t                es_dest,
    input  cpu_isa_pkg::reg_addr_t                ms_dest,
    input  logic                                  es_gr_we,
    input  logic                                  ms_gr_we,
    input  logic                                  rf_we,
    input  cpu_isa_pkg::reg_addr_t                rf_waddr,
    input  cpu_bus_pkg::word_t                    rf_wdata
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic                       ds_valid;
    logic                       ds_ready_go;
    logic [fs_to_ds_bus_wd-1:0] fs_to_ds_bus_r;
    word_t                      ds_inst;
    word_t                      ds_pc;
    logic [5:0]                 op6;
    logic [3:0]                 op4;
    logic [1:0]                 op2;
    logic [4:0]                 op5;
    reg_addr_t                  rd;
    reg_addr_t                  rj;
    reg_addr_t                  rk;
    logic                       is_3r;
    logic                       is_shift;
    logic                       inst_add_w;
    logic                       inst_sub_w;
    logic                       inst_slt;
    logic                       inst_sltu;
    logic                       inst_nor;
    logic                       inst_and;
    logic                       inst_or;
    logic                       inst_xor;
    logic                       inst_slli_w;
    logic                       inst_srli_w;
    logic                       inst_srai_w;
    logic                       inst_addi_w;
    logic                       inst_lu12i_w;
    logic                       inst_ld_w;
    logic                       inst_st_w;
    logic                       inst_jirl;
    logic                       inst_b;
    logic                       inst_bl;
    logic                       inst_beq;
    logic                       inst_bne;
    alu_op_t                    alu_op;
    logic                       src1_is_pc;
    logic                       src2_is_imm;
    logic                       gr_we;
    reg_addr_t                  dest;
    word_t                      imm;
    word_t                      br_offs;
    word_t                      rj_value;
    word_t                      rkd_value;
    reg_addr_t                  rf_raddr2;
    logic                       src1_used;
    logic                       src2_used;
    logic                       hazard;
    logic                       br_taken;
    word_t                      br_target;

    assign {ds_inst, ds_pc} = fs_to_ds_bus_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_bus_r <= fs_to_ds_bus;
        end
    end

    assign op6 = ds_inst[31:26];
    assign op4 = ds_inst[25:22];
    assign op2 = ds_inst[21:20];
    assign op5 = ds_inst[19:15];
    assign rd  = ds_inst[4:0];
    assign rj  = ds_inst[9:5];
    assign rk  = ds_inst[14:10];

    assign is_3r    = op6 == op6_alu && op4 == op4_3r && op2 == op2_3r;
    assign is_shift = op6 == op6_alu && op4 == op4_shift && op2 == op2_shift;

    assign inst_add_w   = is_3r && op5 == op5_add;
    assign inst_sub_w   = is_3r && op5 == op5_sub;
    assign inst_slt     = is_3r && op5 == op5_slt;
    assign inst_sltu    = is_3r && op5 == op5_sltu;
    assign inst_nor     = is_3r && op5 == op5_nor;
    assign inst_and     = is_3r && op5 == op5_and;
    assign inst_or      = is_3r && op5 == op5_or;
    assign inst_xor     = is_3r && op5 == op5_xor;
    assign inst_slli_w  = is_shift && op5 == op5_slli;
    assign inst_srli_w  = is_shift && op5 == op5_srli;
    assign inst_srai_w  = is_shift && op5 == op5_srai;
    assign inst_addi_w  = op6 == op6_alu && op4 == op4_addi;
    assign inst_ld_w    = op6 == op6_mem && op4 == op4_ld;
    assign inst_st_w    = op6 == op6_mem && op4 == op4_st;
    assign inst_lu12i_w = op6 == op6_lu12i && !ds_inst[25];
    assign inst_jirl    = op6 == op6_jirl;
    assign inst_b       = op6 == op6_b;
    assign inst_bl      = op6 == op6_bl;
    assign inst_beq     = op6 == op6_beq;
    assign inst_bne     = op6 == op6_bne;

    // link and address adds go through the adder too
    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                            | inst_jirl | inst_bl;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt;
    assign alu_op[alu_sltu] = inst_sltu;
    assign alu_op[alu_and]  = inst_and;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or;
    assign alu_op[alu_xor]  = inst_xor;
    assign alu_op[alu_sll]  = inst_slli_w;
    assign alu_op[alu_srl]  = inst_srli_w;
    assign alu_op[alu_sra]  = inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_ld_w
                       | inst_st_w | inst_lu12i_w | inst_jirl | inst_bl;

    // pc + 4 for links, si20 << 12 for lu12i, si12 otherwise
    assign imm = src1_is_pc   ? 32'd4 :
                 inst_lu12i_w ? {ds_inst[24:5], 12'b0} :
                                {{20{ds_inst[21]}}, ds_inst[21:10]};

    assign br_offs = (inst_b || inst_bl) ? {{4{ds_inst[9]}}, ds_inst[9:0], ds_inst[25:10], 2'b0}
                                         : {{14{ds_inst[25]}}, ds_inst[25:10], 2'b0};

    assign dest  = inst_bl ? 5'd1 : rd;
    // r0 is never written
    assign gr_we = !inst_st_w && !inst_beq && !inst_bne && !inst_b && dest != 5'd0;

    assign rf_raddr2 = (inst_beq || inst_bne || inst_st_w) ? rd : rk;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .rdata1 (rj_value),
        .raddr2 (rf_raddr2),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    assign src1_used = is_3r | is_shift | inst_addi_w | inst_ld_w | inst_st_w
                     | inst_beq | inst_bne | inst_jirl;
    assign src2_used = is_3r | inst_st_w | inst_beq | inst_bne;

    assign hazard = es_gr_we && (src1_used && es_dest == rj || src2_used && es_dest == rf_raddr2)
                 || ms_gr_we && (src1_used && ms_dest == rj || src2_used && ms_dest == rf_raddr2);

    assign ds_ready_go    = !hazard;
    assign ds_to_es_valid = ds_valid && ds_ready_go;
    assign ds_allowin     = !ds_valid || ds_ready_go && es_allowin;

    assign ds_to_es_bus = {alu_op, inst_ld_w, src1_is_pc, src2_is_imm, gr_we, inst_st_w,
                           dest, imm, rj_value, rkd_value, ds_pc};

    // taken only in the cycle the branch moves on
    assign br_taken  = ds_valid && ds_ready_go && es_allowin
                    && (inst_beq && rj_value == rkd_value || inst_bne && rj_value != rkd_value
                        || inst_jirl || inst_bl || inst_b);
    assign br_target = inst_jirl ? rj_value + {{14{ds_inst[25]}}, ds_inst[25:10], 2'b0}
                                 : ds_pc + br_offs;
    assign br_bus    = {br_taken, br_target};

    // a stalled item stays in decode
    assert property (@(posedge clk) disable iff (reset)
        ds_valid && hazard |=> ds_valid && $stable(fs_to_ds_bus_r));

endmodule

/* design/execute_stage.sv */
module execute_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  ms_allowin,
    output logic                                  es_allowin,
    input  logic                                  ds_to_es_valid,
    input  logic [cpu_bus_pkg::ds_to_es_bus_wd-1:0] ds_to_es_bus,
    output logic                                  es_to_ms_valid,
    output logic [cpu_bus_pkg::es_to_ms_bus_wd-1:0] es_to_ms_bus,
    output cpu_isa_pkg::reg_addr_t                es_dest,
    output logic                                  es_gr_we
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    logic                       es_valid;
    logic [ds_to_es_bus_wd-1:0] ds_to_es_bus_r;
    alu_op_t                    alu_op;
    logic                       es_load;
    logic                       src1_is_pc;
    logic                       src2_is_imm;
    logic                       gr_we;
    logic                       es_store;
    word_t                      imm;
    word_t                      rj_value;
    word_t                      rkd_value;
    word_t                      es_pc;
    word_t                      src1;
    word_t                      src2;
    word_t                      alu_result;

    assign {alu_op, es_load, src1_is_pc, src2_is_imm, gr_we, es_store,
            es_dest, imm, rj_value, rkd_value, es_pc} = ds_to_es_bus_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            ds_to_es_bus_r <= ds_to_es_bus;
        end
    end

    assign src1 = src1_is_pc ? es_pc : rj_value;
    assign src2 = src2_is_imm ? imm : rkd_value;

    // one-hot and-or select, all zero for plain branches
    assign alu_result = {32{alu_op[alu_add]}}  & (src1 + src2)
                      | {32{alu_op[alu_sub]}}  & (src1 - src2)
                      | {32{alu_op[alu_slt]}}  & {31'b0, $signed(src1) < $signed(src2)}
                      | {32{alu_op[alu_sltu]}} & {31'b0, src1 < src2}
                      | {32{alu_op[alu_and]}}  & (src1 & src2)
                      | {32{alu_op[alu_nor]}}  & ~(src1 | src2)
                      | {32{alu_op[alu_or]}}   & (src1 | src2)
                      | {32{alu_op[alu_xor]}}  & (src1 ^ src2)
                      | {32{alu_op[alu_sll]}}  & (src1 << src2[4:0])
                      | {32{alu_op[alu_srl]}}  & (src1 >> src2[4:0])
                      | {32{alu_op[alu_sra]}}  & word_t'($signed(src1) >>> src2[4:0])
                      | {32{alu_op[alu_lui]}}  & src2;

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_gr_we       = es_valid && gr_we;
    assign es_to_ms_bus   = {es_load, es_store, gr_we, es_dest, alu_result, rkd_value};

endmodule

/* design/fetch_stage.sv */
module fetch_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  ds_allowin,
    input  logic [cpu_bus_pkg::br_bus_wd-1:0]       br_bus,
    output logic                                  inst_req,
    output cpu_bus_pkg::word_t                    inst_addr,
    input  logic                                  inst_grant,
    input  cpu_bus_pkg::word_t                    inst_rdata,
    output logic                                  fs_to_ds_valid,
    output logic [cpu_bus_pkg::fs_to_ds_bus_wd-1:0] fs_to_ds_bus
);
    import cpu_bus_pkg::*;

    word_t fs_pc;
    logic  fs_run;
    logic  br_taken;
    word_t br_target;

    assign {br_taken, br_target} = br_bus;

    // fetching starts once reset has been seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_run <= 1'b0;
        end else begin
            fs_run <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= reset_pc;
        end else if (br_taken) begin
            fs_pc <= br_target;
        end else if (inst_req && inst_grant) begin
            fs_pc <= fs_pc + 32'd4;
        end
    end

    assign inst_req  = fs_run && ds_allowin;
    assign inst_addr = fs_pc;

    // word fetched next to a taken branch is wrong path
    assign fs_to_ds_valid = inst_grant && !br_taken;
    assign fs_to_ds_bus   = {inst_rdata, fs_pc};

    assert property (@(posedge clk) reset |-> !inst_req);

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
    input  logic               inst_req,
    input  cpu_bus_pkg::word_t inst_addr,
    output logic               inst_grant,
    output cpu_bus_pkg::word_t inst_rdata,
    input  logic               data_req,
    input  logic               data_we,
    input  cpu_bus_pkg::word_t data_addr,
    input  cpu_bus_pkg::word_t data_wdata,
    output logic               data_grant,
    output cpu_bus_pkg::word_t data_rdata,
    output logic               mem_en,
    output logic               mem_we,
    output cpu_bus_pkg::word_t mem_addr,
    output cpu_bus_pkg::word_t mem_wdata,
    input  cpu_bus_pkg::word_t mem_rdata
);

    // data side wins, fetch retries next cycle
    assign data_grant = data_req;
    assign inst_grant = inst_req && !data_req;

    assign mem_en    = inst_req || data_req;
    assign mem_we    = data_req && data_we;
    assign mem_addr  = data_req ? data_addr : inst_addr;
    assign mem_wdata = data_wdata;

    assign inst_rdata = mem_rdata;
    assign data_rdata = mem_rdata;

    always_comb begin
        assert (!(inst_grant && data_grant));
    end

endmodule

/* design/memwb_stage.sv */
module memwb_stage (
    input  logic                                  clk,
    input  logic                                  reset,
    output logic                                  ms_allowin,
    input  logic                                  es_to_ms_valid,
    input  logic [cpu_bus_pkg::es_to_ms_bus_wd-1:0] es_to_ms_bus,
    output logic                                  data_req,
    output logic                                  data_we,
    output cpu_bus_pkg::word_t                    data_addr,
    output cpu_bus_pkg::word_t                    data_wdata,
    input  logic                                  data_grant,
    input  cpu_bus_pkg::word_t                    data_rdata,
    output cpu_isa_pkg::reg_addr_t                ms_dest,
    output logic                                  ms_gr_we,
    output logic                                  rf_we,
    output cpu_isa_pkg::reg_addr_t                rf_waddr,
    output cpu_bus_pkg::word_t                    rf_wdata
);
    import cpu_bus_pkg::*;

    logic                       ms_valid;
    logic [es_to_ms_bus_wd-1:0] es_to_ms_bus_r;
    logic                       ms_load;
    logic                       ms_store;
    logic                       gr_we;
    word_t                      ms_result;
    word_t                      ms_store_data;
    logic                       ms_ready_go;

    assign {ms_load, ms_store, gr_we, ms_dest, ms_result, ms_store_data} = es_to_ms_bus_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            es_to_ms_bus_r <= es_to_ms_bus;
        end
    end

    // memory ops finish in the cycle of the grant
    assign data_req    = ms_valid && (ms_load || ms_store);
    assign data_we     = data_req && ms_store;
    assign data_addr   = ms_result;
    assign data_wdata  = ms_store_data;
    assign ms_ready_go = !(ms_load || ms_store) || data_grant;
    assign ms_allowin  = !ms_valid || ms_ready_go;

    assign ms_gr_we = ms_valid && gr_we;
    assign rf_we    = ms_gr_we && ms_ready_go;
    assign rf_waddr = ms_dest;
    assign rf_wdata = ms_load ? data_rdata : ms_result;

endmodule

/* design/regfile.sv */
module regfile (
    input  logic                   clk,
    input  cpu_isa_pkg::reg_addr_t raddr1,
    output cpu_bus_pkg::word_t     rdata1,
    input  cpu_isa_pkg::reg_addr_t raddr2,
    output cpu_bus_pkg::word_t     rdata2,
    input  logic                   we,
    input  cpu_isa_pkg::reg_addr_t waddr,
    input  cpu_bus_pkg::word_t     wdata
);
    import cpu_bus_pkg::*;

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 reads as zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

/* project.f */
design/cpu_bus_pkg.sv
design/cpu_isa_pkg.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memwb_stage.sv
design/mem_arbiter.sv
design/cpu_core.sv
testbench/clock_gen.sv
testbench/tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_cpu_core \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* testbench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset drops on a falling edge after ten cycles
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* testbench/cpu_testdata.txt */
# I word: program words from address 0 | W reg value: expected writeback, in order
# S addr value: expected stores, in order (all numbers hex)
I 02801401
I 02bff402
I 00100823
I 00110824
I 00120445
I 00128446
I 00140827
I 00148828
I 00150829
I 0015882a
I 0040902b
I 0044f04c
I 0048844d
I 142468ae
I 02801c20
I 0290000f
I 299001ee
I 289001f0
I 02800611
I 299011f1
I 58000828
I 02800412
I 58000822
I 5c000822
I 02800812
I 5c000828
I 54000c00
I 02800c12
I 02801012
I 02820013
I 4c000274
I 02801412
I 00100695
I 50000000
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 00000008
W 05 00000001
W 06 00000000
W 07 00000002
W 08 00000005
W 09 fffffffd
W 0a fffffff8
W 0b 00000050
W 0c 0000000f
W 0d fffffffe
W 0e 12345000
W 0f 00000400
W 10 12345000
W 11 12345001
W 01 0000006c
W 13 00000080
W 14 0000007c
W 15 000000e8
S 00000800 12345000
S 00000804 12345001

/* testbench/tb_cpu_core.sv */
module tb_cpu_core;
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    localparam int mem_words    = 1024;
    localparam int wait_limit   = 200;
    localparam int quiet_cycles = 50;
    localparam int reset_limit  = 50;

    logic      clk;
    logic      reset;
    logic      mem_en;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    logic      debug_wb_we;
    reg_addr_t debug_wb_addr;
    word_t     debug_wb_data;

    word_t     mem [mem_words];
    reg_addr_t exp_reg [$];
    word_t     exp_wb [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];
    int        wb_idx;
    int        st_idx;
    int        error_count;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cpu_core i_cpu_core (
        .clk           (clk),
        .reset         (reset),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .debug_wb_we   (debug_wb_we),
        .debug_wb_addr (debug_wb_addr),
        .debug_wb_data (debug_wb_data)
    );

    // word memory with combinational reads
    assign mem_rdata = mem[mem_addr[11:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr[11:2]] <= mem_wdata;
        end
    end

    task automatic fail_run(input string reason);
        error_count++;
        $display("ERROR: %s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    prog_count;
        string line;
        byte   tag;
        word_t a;
        word_t b;
        fd = $fopen("testbench/cpu_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open testbench/cpu_testdata.txt");
        end
        prog_count = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1) begin
                tag = line[0];
                a = '0;
                b = '0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                case (tag)
                    "I": begin
                        mem[prog_count] = a;
                        prog_count++;
                    end
                    "W": begin
                        exp_reg.push_back(reg_addr_t'(a));
                        exp_wb.push_back(b);
                    end
                    "S": begin
                        exp_st_addr.push_back(a);
                        exp_st_data.push_back(b);
                    end
                    default: begin
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // compare whatever the core retired in the cycle ending at this edge
    task automatic handle_events(output bit seen);
        seen = 1'b0;
        if (debug_wb_we) begin
            seen = 1'b1;
            if (wb_idx >= exp_wb.size()) begin
                fail_run("writeback seen after all expected writebacks");
            end
            check_value($sformatf("writeback %0d reg", wb_idx),
                        word_t'(exp_reg[wb_idx]), word_t'(debug_wb_addr));
            check_value($sformatf("writeback %0d data", wb_idx), exp_wb[wb_idx], debug_wb_data);
            wb_idx++;
        end
        if (mem_we) begin
            seen = 1'b1;
            if (st_idx >= exp_st_data.size()) begin
                fail_run("store seen after all expected stores");
            end
            check_value($sformatf("store %0d enable", st_idx), 32'd1, word_t'(mem_en));
            check_value($sformatf("store %0d addr", st_idx), exp_st_addr[st_idx], mem_addr);
            check_value($sformatf("store %0d data", st_idx), exp_st_data[st_idx], mem_wdata);
            st_idx++;
        end
    endtask

    initial begin
        int cycles;
        bit seen;
        error_count = 0;
        wb_idx = 0;
        st_idx = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 32'hc0de_0000 | word_t'(i);
        end
        load_testdata();

        cycles = 0;
        while (reset) begin
            @(posedge clk);
            if (debug_wb_we || mem_we || mem_en) begin
                fail_run("memory access or register write while reset is high");
            end
            cycles++;
            if (cycles > reset_limit) begin
                fail_run("reset was never released");
            end
        end

        cycles = 0;
        while (wb_idx < exp_wb.size() || st_idx < exp_st_data.size()) begin
            @(posedge clk);
            handle_events(seen);
            if (seen) begin
                cycles = 0;
            end else begin
                cycles++;
            end
            if (cycles >= wait_limit) begin
                fail_run("core stopped retiring, no writeback or store for 200 cycles");
            end
        end

        // the program ends in a branch to itself so nothing more may retire
        repeat (quiet_cycles) begin
            @(posedge clk);
            handle_events(seen);
        end

        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
